//--- rtl/branch_arbiter.sv
// Branch priority arbiter

`include "branch_cfg.svh"

module branch_arbiter
    import branch_pkg::*;
#(
    parameter int PC_WIDTH     = `BRANCH_PC_WIDTH,
    parameter int BRANCH_COUNT = `BRANCH_COUNT
)
(
    input  logic                             clock,
    input  logic                             arst_n,

    // Strobes and destinations from every table entry
    input  branch_vec_t                      cancels,
    input  branch_vec_t                      jumps,
    input  logic [PC_WIDTH*BRANCH_COUNT-1:0] jump_destinations,

    // Selected outcome, registered
    output logic                             cancel,
    output logic                             jump,
    output pc_t                              jump_destination
);

    // The extra top position stands for "no entry jumps"
    localparam int ALL_COUNT = BRANCH_COUNT + 1;

    // ------------------------------
    // Selection helpers
    // ------------------------------

    // Isolates the lowest set bit, so entry 0 wins over all others
    function automatic logic [ALL_COUNT-1:0] priority_grant(
        input logic [ALL_COUNT-1:0] requests
    );
        return requests & (~requests + ALL_COUNT'(1));
    endfunction

    // One-hot pick of a single bit
    function automatic logic select_bit(
        input logic [ALL_COUNT-1:0] selectors,
        input logic [ALL_COUNT-1:0] bits
    );
        return |(selectors & bits);
    endfunction

    // One-hot pick of an address, zero when no selector is set
    function automatic logic [PC_WIDTH-1:0] select_pc(
        input logic [BRANCH_COUNT-1:0]          selectors,
        input logic [PC_WIDTH*BRANCH_COUNT-1:0] words
    );
        logic [PC_WIDTH-1:0] result;
        result = '0;
        for (int n = 0; n < BRANCH_COUNT; n++) begin
            result |= words[n*PC_WIDTH +: PC_WIDTH] & {PC_WIDTH{selectors[n]}};
        end
        return result;
    endfunction

    // ------------------------------
    // Grant and select
    // ------------------------------

    logic                 jumps_any;
    logic [ALL_COUNT-1:0] requests;
    logic [ALL_COUNT-1:0] grant;
    logic [ALL_COUNT-1:0] cancels_all;
    logic                 cancel_next;
    logic [PC_WIDTH-1:0]  destination_next;

    assign jumps_any = |jumps;
    assign requests  = {!jumps_any, jumps};
    assign grant     = priority_grant(requests);

    // With no jump, any matching entry may still annul its instruction
    assign cancels_all = {|cancels, cancels};
    assign cancel_next = select_bit(grant, cancels_all);

    // Dropping the top grant bit leaves the destination at zero with no jump
    assign destination_next = select_pc(grant[BRANCH_COUNT-1:0], jump_destinations);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cancel           <= 1'b0;
            jump             <= 1'b0;
            jump_destination <= '0;
        end else begin
            cancel           <= cancel_next;
            jump             <= jumps_any;
            jump_destination <= destination_next;
        end
    end

    grant_onehot: assert property (
        @(posedge clock) disable iff (!arst_n) $onehot(grant)
    ) else $error("branch arbiter grant is not one-hot");

    // Downstream relies on a clean zero address when nothing jumps
    idle_destination_zero: assert property (
        @(posedge clock) disable iff (!arst_n) !jump |-> (jump_destination == '0)
    ) else $error("jump_destination nonzero without jump");

endmodule

//--- rtl/branch_cfg.svh
// Branch unit configuration

`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// ------------------------------
// Sizes
// ------------------------------

// Width of every instruction address in the processor
`define BRANCH_PC_WIDTH 10

// Number of entries in the branch table
`define BRANCH_COUNT 4

// Wrong-path instructions already in flight when a redirect leaves the unit
`define BRANCH_SHADOW 2

`endif

//--- rtl/branch_detector.sv
// Branch table entry

module branch_detector
    import branch_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,

    // Table write port, shared by all entries
    input  logic       config_write,
    input  logic       config_select,
    input  pc_t        config_origin,
    input  pc_t        config_destination,
    input  condition_e config_condition,
    input  logic       config_annul_taken,
    input  logic       config_annul_not_taken,

    // Retiring instruction
    input  logic       instr_valid,
    input  pc_t        instr_pc,
    input  logic       flag_zero,
    input  logic       flag_negative,

    // Result of this entry, one cycle after the instruction
    output logic       jump,
    output logic       cancel,
    output pc_t        destination
);

    // ------------------------------
    // Stored entry
    // ------------------------------

    pc_t        origin_q;
    pc_t        destination_q;
    condition_e condition_q;
    logic       annul_taken_q;
    logic       annul_not_taken_q;

    // Only the entry picked by the index decode takes the write
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            origin_q          <= '0;
            destination_q     <= '0;
            condition_q       <= cond_never;
            annul_taken_q     <= 1'b0;
            annul_not_taken_q <= 1'b0;
        end else if (config_write && config_select) begin
            origin_q          <= config_origin;
            destination_q     <= config_destination;
            condition_q       <= config_condition;
            annul_taken_q     <= config_annul_taken;
            annul_not_taken_q <= config_annul_not_taken;
        end
    end

    // ------------------------------
    // Match and condition
    // ------------------------------

    logic matched;
    logic taken;

    // The entry looks only at instructions retiring from its origin
    assign matched = instr_valid && (instr_pc == origin_q);

    always_comb begin
        case (condition_q)
            cond_always:   taken = 1'b1;
            cond_zero:     taken = flag_zero;
            cond_nonzero:  taken = !flag_zero;
            cond_negative: taken = flag_negative;
            // Strictly greater than zero
            cond_positive: taken = !flag_negative && !flag_zero;
            default:       taken = 1'b0;
        endcase
    end

    // ------------------------------
    // Registered result
    // ------------------------------

    // The annul bit follows the direction the branch actually went
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            jump   <= 1'b0;
            cancel <= 1'b0;
        end else begin
            jump   <= matched && taken;
            cancel <= matched && (taken ? annul_taken_q : annul_not_taken_q);
        end
    end

    // The arbiter reads the destination in the same cycle as the strobes
    assign destination = destination_q;

    // An entry left at never must stay silent on the next cycle
    never_no_jump: assert property (
        @(posedge clock) disable iff (!arst_n)
        (condition_q == cond_never) |=> !jump
    ) else $error("branch entry with condition never raised jump");

endmodule

//--- rtl/branch_pkg.sv
// Branch unit types

`include "branch_cfg.svh"

package branch_pkg;

    // ------------------------------
    // Addresses and strobes
    // ------------------------------

    // Any instruction address, origin or destination alike
    typedef logic [`BRANCH_PC_WIDTH-1:0] pc_t;

    // One bit per table entry, bit 0 has the highest priority
    typedef logic [`BRANCH_COUNT-1:0] branch_vec_t;

    // ------------------------------
    // Branch conditions
    // ------------------------------

    // Conditions are tested against the flags of the retiring instruction
    // Encodings 6 and 7 are unused and never take the branch
    typedef enum logic [2:0] {
        cond_never    = 3'd0,
        cond_always   = 3'd1,
        cond_zero     = 3'd2,
        cond_nonzero  = 3'd3,
        cond_negative = 3'd4,
        cond_positive = 3'd5
    } condition_e;

endpackage

//--- rtl/branch_unit_top.sv
// Multiway branch unit

`include "branch_cfg.svh"

module branch_unit_top
    import branch_pkg::*;
(
    input  logic                              clock,
    input  logic                              arst_n,

    // Table write port
    input  logic                              config_write,
    input  logic [$clog2(`BRANCH_COUNT)-1:0]  config_index,
    input  pc_t                               config_origin,
    input  pc_t                               config_destination,
    input  condition_e                        config_condition,
    input  logic                              config_annul_taken,
    input  logic                              config_annul_not_taken,

    // Retiring instruction, one per cycle
    input  logic                              instr_valid,
    input  pc_t                               instr_pc,
    input  logic                              flag_zero,
    input  logic                              flag_negative,

    // Pulses three cycles after the instruction
    output logic                              redirect,
    output logic                              annul,
    output pc_t                               redirect_pc
);

    localparam int INDEX_WIDTH = $clog2(`BRANCH_COUNT);
    localparam int PC_WIDTH    = `BRANCH_PC_WIDTH;

    // ------------------------------
    // Branch table
    // ------------------------------

    branch_vec_t                       jumps;
    branch_vec_t                       cancels;
    logic [PC_WIDTH*`BRANCH_COUNT-1:0] jump_destinations;

    // Every entry sees the same instruction and checks it in parallel
    for (genvar i = 0; i < `BRANCH_COUNT; i++) begin : gen_entry
        branch_detector detector (
            .clock                  (clock),
            .arst_n                 (arst_n),
            .config_write           (config_write),
            .config_select          (config_index == INDEX_WIDTH'(i)),
            .config_origin          (config_origin),
            .config_destination     (config_destination),
            .config_condition       (config_condition),
            .config_annul_taken     (config_annul_taken),
            .config_annul_not_taken (config_annul_not_taken),
            .instr_valid            (instr_valid),
            .instr_pc               (instr_pc),
            .flag_zero              (flag_zero),
            .flag_negative          (flag_negative),
            .jump                   (jumps[i]),
            .cancel                 (cancels[i]),
            .destination            (jump_destinations[i*PC_WIDTH +: PC_WIDTH])
        );
    end

    // ------------------------------
    // Arbitration and redirect
    // ------------------------------

    logic arb_jump;
    logic arb_cancel;
    pc_t  arb_destination;

    branch_arbiter #(
        .PC_WIDTH     (PC_WIDTH),
        .BRANCH_COUNT (`BRANCH_COUNT)
    ) arbiter (
        .clock             (clock),
        .arst_n            (arst_n),
        .cancels           (cancels),
        .jumps             (jumps),
        .jump_destinations (jump_destinations),
        .cancel            (arb_cancel),
        .jump              (arb_jump),
        .jump_destination  (arb_destination)
    );

    redirect_controller controller (
        .clock            (clock),
        .arst_n           (arst_n),
        .jump             (arb_jump),
        .cancel           (arb_cancel),
        .jump_destination (arb_destination),
        .redirect         (redirect),
        .annul            (annul),
        .redirect_pc      (redirect_pc)
    );

endmodule

//--- rtl/redirect_controller.sv
// Redirect and annul controller

`include "branch_cfg.svh"

module redirect_controller
    import branch_pkg::*;
(
    input  logic clock,
    input  logic arst_n,

    // Selected outcome from the arbiter
    input  logic jump,
    input  logic cancel,
    input  pc_t  jump_destination,

    // Pulses to the fetch stage
    output logic redirect,
    output logic annul,
    output pc_t  redirect_pc
);

    localparam int SHADOW_WIDTH = $clog2(`BRANCH_SHADOW + 1);

    // ------------------------------
    // Squash shadow
    // ------------------------------

    // Counts the wrong-path results still to come after a redirect
    logic [SHADOW_WIDTH-1:0] shadow_count;
    logic                    accept;
    logic                    redirect_next;

    // Results arriving inside the shadow belong to squashed instructions
    assign accept        = (shadow_count == '0);
    assign redirect_next = accept && jump;

    // The counter loads on the same edge as the redirect pulse, so the very
    // next arbiter result is already dropped
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            shadow_count <= '0;
        end else if (redirect_next) begin
            shadow_count <= SHADOW_WIDTH'(`BRANCH_SHADOW);
        end else if (!accept) begin
            shadow_count <= shadow_count - 1'b1;
        end
    end

    // ------------------------------
    // Output pulses
    // ------------------------------

    // Each pulse lasts one cycle since the arbiter result changes every cycle
    // and a redirect is always followed by the shadow
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            redirect    <= 1'b0;
            annul       <= 1'b0;
            redirect_pc <= '0;
        end else begin
            redirect    <= redirect_next;
            annul       <= accept && cancel;
            // Held at zero when squashed so the address is clean outside a redirect
            redirect_pc <= accept ? jump_destination : '0;
        end
    end

    // Back-to-back redirects would mean the shadow failed to squash
    no_double_redirect: assert property (
        @(posedge clock) disable iff (!arst_n) redirect |=> !redirect
    ) else $error("redirect asserted on two consecutive cycles");

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the branch unit testbench with Verilator and runs it.
# The simulator exits with a nonzero status when the testbench fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module branch_unit_tb \
    -o branch_unit_sim

./obj_dir/branch_unit_sim

//--- verification/branch_unit_tb.sv
// Branch unit testbench

`include "branch_cfg.svh"

module branch_unit_tb
    import branch_pkg::*;
;

    localparam int INDEX_WIDTH  = $clog2(`BRANCH_COUNT);
    localparam int RESET_CYCLES = 4;

    // Cycle budget of every stimulus phase with one cycle per write or instruction
    localparam int PHASE_IDLE      = 8;
    localparam int PHASE_COND      = 2 * (`BRANCH_COUNT + `BRANCH_COUNT * 4 * 3);
    localparam int PHASE_SHARED    = `BRANCH_COUNT + 4 * 3;
    localparam int PHASE_NOT_TAKEN = `BRANCH_COUNT + 4 * 3 + 1 + 3;
    localparam int PHASE_SQUASH    = `BRANCH_COUNT + 7 + 7;
    localparam int PHASE_RANDOM    = 4 * (`BRANCH_COUNT + 100);
    localparam int DRAIN_CYCLES    = 6;
    localparam int STIMULUS_CYCLES = PHASE_IDLE + PHASE_COND + PHASE_SHARED
                                   + PHASE_NOT_TAKEN + PHASE_SQUASH + PHASE_RANDOM;
    localparam int MAX_CYCLES      = RESET_CYCLES + STIMULUS_CYCLES + DRAIN_CYCLES + 20;

    logic                   clock;
    logic                   arst_n;
    logic                   config_write;
    logic [INDEX_WIDTH-1:0] config_index;
    pc_t                    config_origin;
    pc_t                    config_destination;
    condition_e             config_condition;
    logic                   config_annul_taken;
    logic                   config_annul_not_taken;
    logic                   instr_valid;
    pc_t                    instr_pc;
    logic                   flag_zero;
    logic                   flag_negative;
    logic                   redirect;
    logic                   annul;
    pc_t                    redirect_pc;

    int seed = 15;
    int cycle_count = 0;
    int redirect_seen = 0;
    int annul_seen = 0;

    branch_unit_top UUT (
        .clock                  (clock),
        .arst_n                 (arst_n),
        .config_write           (config_write),
        .config_index           (config_index),
        .config_origin          (config_origin),
        .config_destination     (config_destination),
        .config_condition       (config_condition),
        .config_annul_taken     (config_annul_taken),
        .config_annul_not_taken (config_annul_not_taken),
        .instr_valid            (instr_valid),
        .instr_pc               (instr_pc),
        .flag_zero              (flag_zero),
        .flag_negative          (flag_negative),
        .redirect               (redirect),
        .annul                  (annul),
        .redirect_pc            (redirect_pc)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    // Copy of the branch table that the write port fills as the DUT sees it
    pc_t        ref_origin [`BRANCH_COUNT];
    pc_t        ref_destination [`BRANCH_COUNT];
    condition_e ref_condition [`BRANCH_COUNT];
    logic       ref_annul_taken [`BRANCH_COUNT];
    logic       ref_annul_not_taken [`BRANCH_COUNT];

    // Positive means strictly above zero
    function automatic logic condition_holds(input condition_e cond, input logic zero,
                                             input logic negative);
        case (cond)
            cond_always:   return 1'b1;
            cond_zero:     return zero;
            cond_nonzero:  return !zero;
            cond_negative: return negative;
            cond_positive: return !negative && !zero;
            default:       return 1'b0;
        endcase
    endfunction

    // Expected arbiter outcome for one instruction against the table copy
    function automatic void branch_reference(input pc_t pc, input logic valid,
                                             input logic zero, input logic negative,
                                             output logic jump, output logic cancel,
                                             output pc_t dest);
        logic hit;
        logic taken;
        logic any_cancel;
        jump = 1'b0;
        cancel = 1'b0;
        dest = '0;
        any_cancel = 1'b0;
        for (int i = 0; i < `BRANCH_COUNT; i++) begin
            hit = valid && (pc == ref_origin[i]);
            taken = condition_holds(ref_condition[i], zero, negative);
            if (hit) begin
                any_cancel = any_cancel | (taken ? ref_annul_taken[i] : ref_annul_not_taken[i]);
            end
            // The first taken entry found is the lowest index and wins
            if (hit && taken && !jump) begin
                jump = 1'b1;
                cancel = ref_annul_taken[i];
                dest = ref_destination[i];
            end
        end
        if (!jump) begin
            cancel = any_cancel;
        end
    endfunction

    // Three stages for the entry result, the selected result and the output pulses
    logic stage1_jump, stage1_cancel, stage2_jump, stage2_cancel;
    pc_t  stage1_dest, stage2_dest;
    logic exp_redirect, exp_annul;
    pc_t  exp_pc;
    int   exp_shadow;

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    // Outputs are read before this edge updates them and then the model steps once
    always @(posedge clock) begin
        logic new_jump;
        logic new_cancel;
        pc_t  new_dest;
        logic accept;
        if (!arst_n) begin
            for (int i = 0; i < `BRANCH_COUNT; i++) begin
                ref_origin[i] = '0;
                ref_destination[i] = '0;
                ref_condition[i] = cond_never;
                ref_annul_taken[i] = 1'b0;
                ref_annul_not_taken[i] = 1'b0;
            end
            {stage1_jump, stage1_cancel, stage2_jump, stage2_cancel} = '0;
            stage1_dest = '0;
            stage2_dest = '0;
            exp_redirect = 1'b0;
            exp_annul = 1'b0;
            exp_pc = '0;
            exp_shadow = 0;
        end else begin
            check_flag("redirect", redirect, exp_redirect);
            check_flag("annul", annul, exp_annul);
            check_pc("redirect_pc", redirect_pc, exp_pc);
            if (redirect) redirect_seen++;
            if (annul) annul_seen++;
            // Output stage with the squash shadow after a redirect
            accept = (exp_shadow == 0);
            exp_redirect = accept && stage2_jump;
            exp_annul = accept && stage2_cancel;
            exp_pc = accept ? stage2_dest : '0;
            if (exp_redirect) begin
                exp_shadow = `BRANCH_SHADOW;
            end else if (!accept) begin
                exp_shadow = exp_shadow - 1;
            end
            stage2_jump = stage1_jump;
            stage2_cancel = stage1_cancel;
            stage2_dest = stage1_dest;
            // The instruction on this edge still sees the table before the write
            branch_reference(instr_pc, instr_valid, flag_zero, flag_negative,
                             new_jump, new_cancel, new_dest);
            stage1_jump = new_jump;
            stage1_cancel = new_cancel;
            stage1_dest = new_dest;
            if (config_write) begin
                ref_origin[config_index] = config_origin;
                ref_destination[config_index] = config_destination;
                ref_condition[config_index] = config_condition;
                ref_annul_taken[config_index] = config_annul_taken;
                ref_annul_not_taken[config_index] = config_annul_not_taken;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Test FAILED");
            $fatal(1, "Timeout: the stimulus did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------

    task automatic write_entry(input int index, input pc_t origin, input pc_t destination,
                               input condition_e cond, input logic annul_taken,
                               input logic annul_not_taken);
        @(negedge clock);
        config_write = 1'b1;
        config_index = INDEX_WIDTH'(index);
        config_origin = origin;
        config_destination = destination;
        config_condition = cond;
        config_annul_taken = annul_taken;
        config_annul_not_taken = annul_not_taken;
        instr_valid = 1'b0;
    endtask

    task automatic issue(input pc_t pc, input logic valid, input logic zero,
                         input logic negative);
        @(negedge clock);
        config_write = 1'b0;
        instr_valid = valid;
        instr_pc = pc;
        flag_zero = zero;
        flag_negative = negative;
    endtask

    task automatic bubbles(input int count);
        for (int n = 0; n < count; n++) begin
            issue(10'h000, 1'b0, 1'b0, 1'b0);
        end
    endtask

    // One entry per condition is hit with every flag pair and spaced past the shadow
    task automatic condition_round(input condition_e c0, input condition_e c1,
                                   input condition_e c2, input condition_e c3,
                                   input pc_t base);
        condition_e conds [4];
        conds = '{c0, c1, c2, c3};
        for (int e = 0; e < `BRANCH_COUNT; e++) begin
            write_entry(e, base + pc_t'(e * 16), base + pc_t'(128 + e), conds[e], e[0], e[1]);
        end
        for (int e = 0; e < `BRANCH_COUNT; e++) begin
            for (int f = 0; f < 4; f++) begin
                issue(base + pc_t'(e * 16), 1'b1, f[0], f[1]);
                bubbles(2);
            end
        end
    endtask

    // Origins crowd into eight addresses so entries overlap and match often
    task automatic random_block();
        int r;
        for (int e = 0; e < `BRANCH_COUNT; e++) begin
            r = $random(seed);
            write_entry(e, {7'h7E, r[2:0]}, r[12:3], condition_e'($unsigned(r[31:16]) % 6),
                        r[13], r[14]);
        end
        for (int k = 0; k < 100; k++) begin
            r = $random(seed);
            issue({7'h7E, r[2:0]}, r[4:3] != 2'b00, r[5], r[6]);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        int r;
        arst_n = 1'b0;
        config_write = 1'b0;
        config_index = '0;
        config_origin = '0;
        config_destination = '0;
        config_condition = cond_never;
        config_annul_taken = 1'b0;
        config_annul_not_taken = 1'b0;
        instr_valid = 1'b0;
        instr_pc = '0;
        flag_zero = 1'b0;
        flag_negative = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        arst_n = 1'b1;

        // The table is empty so nothing may redirect
        for (int k = 0; k < PHASE_IDLE; k++) begin
            r = $random(seed);
            issue(r[9:0], 1'b1, r[10], r[11]);
        end

        condition_round(cond_never, cond_always, cond_zero, cond_nonzero, 10'h010);
        condition_round(cond_negative, cond_positive, cond_always, cond_nonzero, 10'h050);

        // Entries 0 and 2 both take at 0x100 and entry 0 must win with its own annul bit
        write_entry(0, 10'h100, 10'h111, cond_always, 1'b0, 1'b0);
        write_entry(1, 10'h100, 10'h122, cond_never, 1'b0, 1'b1);
        write_entry(2, 10'h100, 10'h133, cond_always, 1'b1, 1'b1);
        write_entry(3, 10'h104, 10'h144, cond_zero, 1'b1, 1'b1);
        for (int f = 0; f < 4; f++) begin
            issue(10'h100, 1'b1, f[0], f[1]);
            bubbles(2);
        end

        // All entries match 0x200 but only take on zero
        for (int e = 0; e < `BRANCH_COUNT; e++) begin
            write_entry(e, 10'h200, 10'h210 + pc_t'(e), cond_zero, 1'b1, e == 1);
        end
        for (int f = 0; f < 4; f++) begin
            issue(10'h200, 1'b1, f[0], f[1]);
            bubbles(2);
        end
        write_entry(1, 10'h200, 10'h211, cond_zero, 1'b1, 1'b0);
        issue(10'h200, 1'b1, 1'b0, 1'b0);
        bubbles(2);

        // Back-to-back taken branches where the two after a redirect are wrong-path
        write_entry(0, 10'h300, 10'h3A0, cond_always, 1'b1, 1'b0);
        write_entry(1, 10'h304, 10'h3B0, cond_always, 1'b1, 1'b0);
        write_entry(2, 10'h308, 10'h3C0, cond_always, 1'b0, 1'b0);
        write_entry(3, 10'h30C, 10'h3D0, cond_zero, 1'b1, 1'b1);
        issue(10'h300, 1'b1, 1'b0, 1'b0);
        issue(10'h304, 1'b1, 1'b0, 1'b0);
        issue(10'h308, 1'b1, 1'b0, 1'b0);
        issue(10'h30C, 1'b1, 1'b1, 1'b0);
        bubbles(3);
        issue(10'h304, 1'b1, 1'b0, 1'b0);
        issue(10'h30C, 1'b1, 1'b0, 1'b0);
        issue(10'h300, 1'b1, 1'b0, 1'b0);
        issue(10'h308, 1'b1, 1'b0, 1'b0);
        bubbles(3);

        repeat (4) random_block();
        bubbles(DRAIN_CYCLES);

        if (redirect_seen == 0 || annul_seen == 0) begin
            $display("Test FAILED");
            $fatal(1, "The run never saw both a redirect pulse and an annul pulse");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/branch_pkg.sv
rtl/branch_detector.sv
rtl/branch_arbiter.sv
rtl/redirect_controller.sv
rtl/branch_unit_top.sv
verification/branch_unit_tb.sv
